// ==== all.f ====
+incdir+common
common/screenPkg.sv
common/tilePkg.sv
fortressMap/tileAddressDecoder.sv
fortressMap/mapRow.sv
design/pixelShader.sv
design/fortressRenderer.sv
dv/fortressRendererTb.sv

// ==== common/fortress_config.svh ====
//////////////////////////////////////////////////
// fortress renderer constants
// screen and tile geometry, hit threshold, colours
//////////////////////////////////////////////////
`ifndef FORTRESS_CONFIG_SVH
`define FORTRESS_CONFIG_SVH

// 16x16 map of 32x32 pixel tiles
`define TILE_COUNT 16
`define TILE_BITS 4
`define PIXEL_BITS 5

// offsets come from the screen counters
`define OFFSET_BITS 11

// levels 0..2 are fortresses, 3 is the empty map
`define LEVEL_COUNT 4

// speed sum must be strictly above this to break a wall
`define HIT_THRESHOLD 500

`define TRANSPARENT_RGB 8'hFF
`define WALL_RGB 8'h00

`endif

// ==== common/screenPkg.sv ====
//////////////////////////////////////////////////
// screen geometry types
// offsets, tile and in-tile pixel indices, level
//////////////////////////////////////////////////
`default_nettype none

`include "fortress_config.svh"

package screenPkg;

  // offset from the top left corner of the fortress rectangle
  typedef logic [`OFFSET_BITS-1:0] offsetT;

  // offset bits 8..5 pick the tile
  typedef logic [`TILE_BITS-1:0] tileIdxT;

  // offset bits 4..0 pick the pixel inside the tile
  typedef logic [`PIXEL_BITS-1:0] pixelIdxT;

  typedef logic [$clog2(`LEVEL_COUNT)-1:0] levelT;

  // bird speed sum, same range as the offsets
  typedef logic [`OFFSET_BITS-1:0] speedT;

endpackage

`default_nettype wire

// ==== common/tilePkg.sv ====
//////////////////////////////////////////////////
// tile content: colour and map row types,
// level map tables and the wall sprite mask
//////////////////////////////////////////////////
`default_nettype none

`include "fortress_config.svh"

package tilePkg;
  import screenPkg::*;

  typedef logic [7:0] rgbT;

  // one wall-present bit per column, column 0 leftmost
  typedef logic [0:`TILE_COUNT-1] mapRowT;

  // built-in fortress maps, rows not listed are empty
  function automatic mapRowT levelRow(input levelT lvl, input tileIdxT row);
    mapRowT bits;
    bits = '0;
    case (lvl)
      2'd0: begin // small tower
        case (row)
          4'd10: bits = 16'b0000000001100000;
          4'd11, 4'd12: bits = 16'b0000000001000000;
          default: bits = '0;
        endcase
      end
      2'd1: begin // walled yard with battlements
        case (row)
          4'd7: bits = 16'b0000000001010100;
          4'd8, 4'd12: bits = 16'b0000000001111100;
          4'd9, 4'd10, 4'd11: bits = 16'b0000000001000100;
          default: bits = '0;
        endcase
      end
      2'd2: begin // twin towers
        case (row)
          4'd5: bits = 16'b0000000011000110;
          4'd6: bits = 16'b0000000011010110;
          4'd7, 4'd8, 4'd12: bits = 16'b0000000011111110;
          4'd9, 4'd10, 4'd11: bits = 16'b0000000011000110;
          default: bits = '0;
        endcase
      end
      default: bits = '0; // empty level
    endcase
    return bits;
  endfunction

  // 32x32 wall sprite, 1 where the brick outline is drawn
  function automatic logic wallSpriteBit(input pixelIdxT row, input pixelIdxT col);
    logic [0:31] rowBits;
    case (row)
      5'd0: rowBits = 32'h03E0_0000;
      5'd1: rowBits = 32'h07F0_0000;
      5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7: rowBits = 32'h0618_0000;
      5'd8: rowBits = 32'h0630_0000;
      5'd9: rowBits = 32'h0660_0000;
      5'd10: rowBits = 32'h07C0_0000;
      5'd11: rowBits = 32'h0780_0000;
      5'd22: rowBits = 32'h0633_8000;
      5'd23, 5'd26, 5'd30, 5'd31: rowBits = 32'h0637_8000;
      5'd24: rowBits = 32'h0605_8000;
      5'd25: rowBits = 32'h0635_8000;
      5'd27, 5'd28, 5'd29: rowBits = 32'h0631_8000;
      default: rowBits = 32'h0600_0000; // plain stem, rows 12..21
    endcase
    return rowBits[col];
  endfunction

endpackage

`default_nettype wire

// ==== design/fortressRenderer.sv ====
//////////////////////////////////////////////////
// fortress renderer top
// address decoder, 16 map rows, pixel shader
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fortress_config.svh"

module fortressRenderer
  import screenPkg::*;
  import tilePkg::*;
(
  input logic clk,
  input logic resetN,
  input offsetT offsetX,
  input offsetT offsetY,
  input logic insideRectangle,
  input levelT level,
  input speedT speedSum,
  input logic birdWallCollision,
  output rgbT rgbOut,
  output logic drawingRequest
);

  tileIdxT tileRow;
  tileIdxT tileCol;
  pixelIdxT pixelRow;
  pixelIdxT pixelCol;
  logic reload;
  levelT loadLevel;
  logic [`TILE_COUNT-1:0] eraseRow;
  mapRowT [0:`TILE_COUNT-1] rows;

  tileAddressDecoder uDecoder (
    .clk,
    .resetN,
    .offsetX,
    .offsetY,
    .level,
    .speedSum,
    .birdWallCollision,
    .tileRow,
    .tileCol,
    .pixelRow,
    .pixelCol,
    .reload,
    .loadLevel,
    .eraseRow
  );

  // one register row per map line
  for (genvar r = 0; r < `TILE_COUNT; r++) begin : gRow
    mapRow #(.rowIndex(r)) uRow (
      .clk,
      .resetN,
      .reload,
      .loadLevel,
      .erase(eraseRow[r]),
      .tileCol,
      .tiles(rows[r])
    );
  end

  pixelShader uShader (
    .clk,
    .resetN,
    .insideRectangle,
    .tileRow,
    .pixelRow,
    .pixelCol,
    .tileCol,
    .rows,
    .rgbOut,
    .drawingRequest
  );

endmodule

`default_nettype wire

// ==== design/pixelShader.sv ====
//////////////////////////////////////////////////
// pixel shader: row and tile select, sprite lookup,
// registered colour and drawing request
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fortress_config.svh"

module pixelShader
  import screenPkg::*;
  import tilePkg::*;
(
  input logic clk,
  input logic resetN,
  input logic insideRectangle,
  input tileIdxT tileRow,
  input pixelIdxT pixelRow,
  input pixelIdxT pixelCol,
  input tileIdxT tileCol,
  input mapRowT [0:`TILE_COUNT-1] rows,
  output rgbT rgbOut,
  output logic drawingRequest
);

  mapRowT curRow;
  logic tilePresent;
  logic spriteBit;
  rgbT nextRgb;

  assign curRow = rows[tileRow];
  assign tilePresent = curRow[tileCol];
  assign spriteBit = wallSpriteBit(pixelRow, pixelCol);

  // only a present tile with a set mask bit is painted
  assign nextRgb = (insideRectangle && tilePresent && spriteBit) ?
                   rgbT'(`WALL_RGB) : rgbT'(`TRANSPARENT_RGB);

  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      rgbOut <= rgbT'(`TRANSPARENT_RGB);
    end else begin
      rgbOut <= nextRgb;
    end
  end

  assign drawingRequest = (rgbOut != rgbT'(`TRANSPARENT_RGB)); // follows the registered pixel

endmodule

`default_nettype wire

// ==== dv/fortressRendererTb.sv ====
//////////////////////////////////////////////////
// fortress renderer testbench: clock, reset,
// reference map model, stimulus table, random phase
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fortress_config.svh"

module fortressRendererTb
  import screenPkg::*;
  import tilePkg::*;
();

  typedef struct packed {
    offsetT ox;
    offsetT oy;
    logic ins;
    levelT lvl;
    speedT spd;
    logic col;
  } stepT;

  logic clk;
  logic resetN;
  offsetT offsetX;
  offsetT offsetY;
  logic insideRectangle;
  levelT level;
  speedT speedSum;
  logic birdWallCollision;
  rgbT rgbOut;
  logic drawingRequest;

  stepT steps[$];
  string names[$];
  mapRowT modelMap [0:`TILE_COUNT-1];
  levelT modelLevel;
  rgbT expRgb;
  string curName;
  string pendingName;
  logic pendingValid;
  logic resetChecked;
  int rgbErrors;
  int drawErrors;
  int cycleLimit;
  int cycles;
  logic [31:0] rnd;
  levelT randLevel;
  stepT s;

  fortressRenderer dut (
    .clk,
    .resetN,
    .offsetX,
    .offsetY,
    .insideRectangle,
    .level,
    .speedSum,
    .birdWallCollision,
    .rgbOut,
    .drawingRequest
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic addStep(input string name, input int ox, input int oy, input logic ins,
                         input int lvl, input int spd, input logic col);
    stepT st;
    st.ox = offsetT'(ox);
    st.oy = offsetT'(oy);
    st.ins = ins;
    st.lvl = levelT'(lvl);
    st.spd = speedT'(spd);
    st.col = col;
    steps.push_back(st);
    names.push_back(name);
  endtask

  // tile at row 10 col 9 holds a level 0 wall and sprite row 0 is set at cols 6..10
  task automatic buildTable();
    addStep("l0 wall", 294, 320, 1'b1, 0, 0, 1'b0);
    addStep("l0 sprite gap", 288, 320, 1'b1, 0, 0, 1'b0);
    addStep("l0 outside rect", 294, 320, 1'b0, 0, 0, 1'b0);
    addStep("l0 empty tile", 294, 0, 1'b1, 0, 0, 1'b0);
    addStep("l0 sprite stem", 293, 367, 1'b1, 0, 0, 1'b0);
    addStep("switch to l1", 294, 256, 1'b1, 1, 0, 1'b0); // still old map
    addStep("l1 wall", 294, 256, 1'b1, 1, 0, 1'b0);
    addStep("switch to l2", 262, 224, 1'b1, 2, 0, 1'b0);
    addStep("l2 wall", 262, 224, 1'b1, 2, 0, 1'b0);
    addStep("switch to l3", 262, 224, 1'b1, 3, 0, 1'b0);
    addStep("l3 empty", 262, 224, 1'b1, 3, 0, 1'b0);
    addStep("l3 empty tower", 294, 320, 1'b1, 3, 0, 1'b0);
    addStep("back to l0", 294, 320, 1'b1, 0, 0, 1'b0);
    addStep("l0 again", 294, 320, 1'b1, 0, 0, 1'b0);
    addStep("hit at threshold", 294, 320, 1'b1, 0, 500, 1'b1);
    addStep("after 500 hit", 294, 320, 1'b1, 0, 0, 1'b0);
    addStep("hit above threshold", 294, 320, 1'b1, 0, 501, 1'b1);
    addStep("after 501 hit", 294, 320, 1'b1, 0, 0, 1'b0);
    addStep("neighbour kept", 326, 320, 1'b1, 0, 0, 1'b0);
    addStep("leave l0", 294, 320, 1'b1, 1, 0, 1'b0);
    addStep("l1 on erased spot", 294, 320, 1'b1, 1, 0, 1'b0);
    addStep("return to l0", 294, 320, 1'b1, 0, 0, 1'b0);
    addStep("tile restored", 294, 320, 1'b1, 0, 0, 1'b0);
  endtask

  task automatic driveStep(input stepT st, input string name);
    offsetX <= st.ox;
    offsetY <= st.oy;
    insideRectangle <= st.ins;
    level <= st.lvl;
    speedSum <= st.spd;
    birdWallCollision <= st.col;
    curName = name;
  endtask

  task automatic loadModel(input levelT lvl);
    for (int r = 0; r < `TILE_COUNT; r++) begin
      modelMap[r] = levelRow(lvl, tileIdxT'(r));
    end
    modelLevel = lvl;
  endtask

  // changes that land on the coming rising edge
  task automatic updateModel();
    if (level != modelLevel) begin
      loadModel(level);
    end else if (birdWallCollision && speedSum > speedT'(`HIT_THRESHOLD)) begin
      modelMap[offsetY[8:5]][offsetX[8:5]] = 1'b0;
    end
  endtask

  function automatic rgbT predictPixel();
    if (insideRectangle && modelMap[offsetY[8:5]][offsetX[8:5]] &&
        wallSpriteBit(offsetY[4:0], offsetX[4:0])) begin
      return rgbT'(`WALL_RGB);
    end
    return rgbT'(`TRANSPARENT_RGB);
  endfunction

  task automatic checkRgb(input string name, input rgbT exp, input rgbT act);
    if (act !== exp) begin
      $display("FAIL %s: rgbOut expected %h, got %h", name, exp, act);
      rgbErrors++;
    end
  endtask

  task automatic checkDraw(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: drawingRequest expected %b, got %b", name, exp, act);
      drawErrors++;
    end
  endtask

  // inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin
    if (resetN !== 1'b1) begin
      loadModel(levelT'(0));
      pendingValid = 1'b0;
    end else begin
      if (!resetChecked) begin
        checkRgb("after reset", rgbT'(`TRANSPARENT_RGB), rgbOut);
        checkDraw("after reset", 1'b0, drawingRequest);
        resetChecked = 1'b1;
      end
      if (pendingValid) begin
        checkRgb(pendingName, expRgb, rgbOut);
        checkDraw(pendingName, expRgb != rgbT'(`TRANSPARENT_RGB), drawingRequest);
      end
      expRgb = predictPixel();
      pendingName = curName;
      pendingValid = 1'b1;
      updateModel();
    end
  end

  initial begin : watchdog
    cycles = 0;
    wait (cycleLimit > 0);
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Errors found");
    $finish;
  end

  initial begin
    resetN <= 1'b0;
    offsetX <= '0;
    offsetY <= '0;
    insideRectangle <= 1'b0;
    level <= '0;
    speedSum <= '0;
    birdWallCollision <= 1'b0;
    curName = "idle";
    rgbErrors = 0;
    drawErrors = 0;
    pendingValid = 1'b0;
    resetChecked = 1'b0;
    rnd = 32'hdcc1;
    randLevel = '0;
    buildTable();
    cycleLimit = steps.size() + 200 + 50;
    repeat (5) @(posedge clk);
    resetN <= 1'b1;
    foreach (steps[i]) begin
      @(posedge clk);
      driveStep(steps[i], names[i]);
    end
    // random pixels over the fortress area with offsets below 512
    for (int i = 0; i < 200; i++) begin
      rnd = lcgNext(rnd);
      s.ox = offsetT'(256 + int'(rnd[23:16]));
      rnd = lcgNext(rnd);
      s.oy = offsetT'(160 + int'(rnd[23:16]));
      rnd = lcgNext(rnd);
      s.ins = rnd[17] | rnd[18];
      s.col = rnd[19];
      s.spd = rnd[30:20];
      if (rnd[27:24] == 4'd0) begin
        randLevel = rnd[29:28]; // occasional level change
      end
      s.lvl = randLevel;
      @(posedge clk);
      driveStep(s, $sformatf("random %0d", i));
    end
    s.ins = 1'b0;
    s.col = 1'b0;
    @(posedge clk);
    driveStep(s, "idle");
    repeat (2) @(posedge clk);
    $display("rgb errors: %0d, draw errors: %0d", rgbErrors, drawErrors);
    if (rgbErrors + drawErrors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fortressMap/mapRow.sv ====
//////////////////////////////////////////////////
// map row: 16 wall-present bits
// with level reload and single-tile erase
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mapRow
  import screenPkg::*;
  import tilePkg::*;
#(
  parameter int rowIndex = 0
)
(
  input logic clk,
  input logic resetN,
  input logic reload,
  input levelT loadLevel,
  input logic erase,
  input tileIdxT tileCol,
  output mapRowT tiles
);

  localparam tileIdxT thisRow = tileIdxT'(rowIndex);

  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      tiles <= levelRow('0, thisRow); // level 0 after reset
    end else if (reload) begin
      tiles <= levelRow(loadLevel, thisRow);
    end else if (erase) begin
      tiles[tileCol] <= 1'b0; // wall broken by the bird
    end
  end

endmodule

`default_nettype wire

// ==== fortressMap/tileAddressDecoder.sv ====
//////////////////////////////////////////////////
// tile address decoder: offset split, loaded level,
// reload strobe and one-hot row erase
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fortress_config.svh"

module tileAddressDecoder
  import screenPkg::*;
(
  input logic clk,
  input logic resetN,
  input offsetT offsetX,
  input offsetT offsetY,
  input levelT level,
  input speedT speedSum,
  input logic birdWallCollision,
  output tileIdxT tileRow,
  output tileIdxT tileCol,
  output pixelIdxT pixelRow,
  output pixelIdxT pixelCol,
  output logic reload,
  output levelT loadLevel,
  output logic [`TILE_COUNT-1:0] eraseRow
);

  levelT loadedLevel;
  logic hit;

  assign tileRow = offsetY[`TILE_BITS+`PIXEL_BITS-1:`PIXEL_BITS];
  assign tileCol = offsetX[`TILE_BITS+`PIXEL_BITS-1:`PIXEL_BITS];
  assign pixelRow = offsetY[`PIXEL_BITS-1:0];
  assign pixelCol = offsetX[`PIXEL_BITS-1:0];

  // rows take the new map on the same edge the level is registered
  assign reload = (level != loadedLevel);
  assign loadLevel = level;

  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      loadedLevel <= '0;
    end else if (reload) begin
      loadedLevel <= level;
    end
  end

  // a fresh map wins over a wall hit on the same edge
  assign hit = birdWallCollision && (speedSum > speedT'(`HIT_THRESHOLD)) && !reload;
  assign eraseRow = hit ? (`TILE_COUNT'(1) << tileRow) : '0;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the fortress renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module fortressRendererTb \
  -o fortressRendererSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/fortressRendererSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0
